//--- eth_pkg.sv
package eth_pkg;

    // One GMII data byte
    typedef logic [7:0] octet_t;

    // Ethernet station address
    typedef logic [47:0] mac_addr_t;

    // Type/length field of the frame
    typedef logic [15:0] ethertype_t;

    // Header as it arrives on the wire, destination first
    typedef struct packed {
        mac_addr_t  dst_mac;
        mac_addr_t  src_mac;
        ethertype_t ethertype;
    } eth_header_t;

    // Preamble and start-of-frame delimiter
    localparam octet_t preamble_octet = 8'h55;
    localparam octet_t sfd_octet = 8'hD5;

    // Header bytes after the SFD
    localparam int header_len = 14;

    localparam ethertype_t ethertype_arp = 16'h0806;
    localparam mac_addr_t mac_broadcast = '1;

endpackage

//--- shell_pkg.sv
package shell_pkg;

    // One-cycle outcome pulses, one frame at most per pulse
    typedef struct packed {
        logic frame_ok;
        logic arp_ok;
        logic frame_err;
    } rx_event_t;

    // Board LED vector
    typedef logic [3:0] led_t;

    // LED bit positions
    localparam int led_heartbeat = 0;
    localparam int led_arp = 1;
    localparam int led_rx = 2;
    // Error activity sits where TX activity used to be
    localparam int led_err = 3;

endpackage

//--- gmii_rx_parser.sv
`timescale 1ns/1ps

module gmii_rx_parser (
    input  logic            clk_1x_90,
    input  logic            arst_n,
    input  eth_pkg::octet_t gmii_rxd,
    input  logic            gmii_rx_dv,
    input  logic            gmii_rx_er,
    output eth_pkg::octet_t hdr_byte,
    output logic            hdr_byte_en,
    output logic            hdr_done,
    output logic            frame_end,
    output logic            frame_bad
);
    import eth_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_preamble,
        st_header,
        st_payload,
        st_drop
    } rx_state_t;

    rx_state_t  state;
    rx_state_t  state_nxt;
    octet_t     rxd_q;
    logic       dv_q;
    logic       er_q;
    logic [3:0] hdr_cnt;
    logic       bad_set;

    // Input register, data carries no reset
    always_ff @(posedge clk_1x_90) begin
        rxd_q <= gmii_rxd;
    end

    always_ff @(posedge clk_1x_90 or negedge arst_n) begin
        if (!arst_n) begin
            dv_q <= 1'b0;
            er_q <= 1'b0;
        end else begin
            dv_q <= gmii_rx_dv;
            er_q <= gmii_rx_er;
        end
    end

    // Next state
    always_comb begin
        state_nxt = state;
        bad_set = 1'b0;
        case (state)
            st_idle: begin
                // First valid byte must already be preamble
                if (dv_q) begin
                    if (er_q || (rxd_q != preamble_octet)) begin
                        state_nxt = st_drop;
                        bad_set = 1'b1;
                    end else begin
                        state_nxt = st_preamble;
                    end
                end
            end
            st_preamble: begin
                if (!dv_q) begin
                    state_nxt = st_idle;
                end else if (er_q) begin
                    state_nxt = st_drop;
                    bad_set = 1'b1;
                end else if (rxd_q == sfd_octet) begin
                    state_nxt = st_header;
                end else if (rxd_q != preamble_octet) begin
                    state_nxt = st_drop;
                    bad_set = 1'b1;
                end
            end
            st_header: begin
                if (!dv_q) begin
                    state_nxt = st_idle;
                end else if (er_q) begin
                    state_nxt = st_drop;
                    bad_set = 1'b1;
                end else if (hdr_cnt == 4'(header_len - 1)) begin
                    state_nxt = st_payload;
                end
            end
            st_payload: begin
                if (!dv_q) begin
                    state_nxt = st_idle;
                end else if (er_q) begin
                    state_nxt = st_drop;
                    bad_set = 1'b1;
                end
            end
            st_drop: begin
                // Wait out the rest of the frame
                if (!dv_q) begin
                    state_nxt = st_idle;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk_1x_90 or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            hdr_cnt <= '0;
            hdr_done <= 1'b0;
            frame_end <= 1'b0;
            frame_bad <= 1'b0;
        end else begin
            state <= state_nxt;
            // Byte index within the header
            if (state != st_header) begin
                hdr_cnt <= '0;
            end else if (hdr_byte_en) begin
                hdr_cnt <= hdr_cnt + 4'd1;
            end
            hdr_done <= (state == st_header) && (state_nxt == st_payload);
            // Only frames past the SFD or flagged bad report an end
            frame_end <= !dv_q && ((state == st_header) || (state == st_payload) ||
                                   (state == st_drop));
            // Held through the frame_end cycle
            if (bad_set) begin
                frame_bad <= 1'b1;
            end else if (frame_end) begin
                frame_bad <= 1'b0;
            end
        end
    end

    // Strobe in the same cycle the byte sits in the input register
    assign hdr_byte = rxd_q;
    assign hdr_byte_en = (state == st_header) && dv_q;

endmodule

//--- rx_header_decode.sv
`timescale 1ns/1ps

module rx_header_decode #(
    parameter eth_pkg::mac_addr_t station_mac = 48'h125555000126
) (
    input  logic                 clk_1x_90,
    input  logic                 arst_n,
    input  eth_pkg::octet_t      hdr_byte,
    input  logic                 hdr_byte_en,
    input  logic                 hdr_done,
    input  logic                 frame_end,
    input  logic                 frame_bad,
    output shell_pkg::rx_event_t rx_event
);
    import eth_pkg::*;

    eth_header_t hdr_q;
    logic        hdr_complete;
    logic        mac_match;
    logic        is_arp;

    // Header shift register, first byte ends up on top
    always_ff @(posedge clk_1x_90) begin
        if (hdr_byte_en) begin
            hdr_q <= {hdr_q[$bits(eth_header_t)-9:0], hdr_byte};
        end
    end

    always_ff @(posedge clk_1x_90 or negedge arst_n) begin
        if (!arst_n) begin
            hdr_complete <= 1'b0;
            mac_match <= 1'b0;
            is_arp <= 1'b0;
            rx_event <= '0;
        end else begin
            rx_event <= '0;
            // Last header byte was shifted in the cycle before
            if (hdr_done) begin
                hdr_complete <= 1'b1;
                mac_match <= (hdr_q.dst_mac == station_mac) ||
                             (hdr_q.dst_mac == mac_broadcast);
                is_arp <= (hdr_q.ethertype == ethertype_arp);
            end
            // One outcome per frame
            if (frame_end) begin
                hdr_complete <= 1'b0;
                mac_match <= 1'b0;
                is_arp <= 1'b0;
                if (frame_bad || !hdr_complete) begin
                    // Bad bytes or a runt header
                    rx_event.frame_err <= 1'b1;
                end else if (mac_match) begin
                    rx_event.frame_ok <= 1'b1;
                    rx_event.arp_ok <= is_arp;
                end
                // Clean frame for someone else stays silent
            end
        end
    end

endmodule

//--- activity_stretch.sv
`timescale 1ns/1ps

module activity_stretch #(
    parameter int stretch_dw = 22
) (
    input  logic clk_1x_90,
    input  logic arst_n,
    input  logic trig,
    output logic active
);

    logic [stretch_dw-1:0] hold_cnt;

    // Retriggerable down-counter
    always_ff @(posedge clk_1x_90 or negedge arst_n) begin
        if (!arst_n) begin
            hold_cnt <= '0;
        end else if (trig) begin
            hold_cnt <= '1;
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    // Trigger cycle plus the full count gives 2**stretch_dw after the output register
    assign active = trig || (hold_cnt != '0);

endmodule

//--- status_leds.sv
`timescale 1ns/1ps

module status_leds #(
    parameter int stretch_dw = 22,
    parameter int blink_dw = 25
) (
    input  logic                 clk_1x_90,
    input  logic                 arst_n,
    input  shell_pkg::rx_event_t rx_event,
    output shell_pkg::led_t      led
);
    import shell_pkg::*;

    logic [blink_dw-1:0] blink_cnt;
    logic                arp_active;
    logic                rx_active;
    logic                err_active;
    led_t                led_nxt;

    // Free-running heartbeat divider
    always_ff @(posedge clk_1x_90 or negedge arst_n) begin
        if (!arst_n) begin
            blink_cnt <= '0;
        end else begin
            blink_cnt <= blink_cnt + 1'b1;
        end
    end

    activity_stretch #(.stretch_dw(stretch_dw)) u_arp_stretch (
        .clk_1x_90 (clk_1x_90),
        .arst_n    (arst_n),
        .trig      (rx_event.arp_ok),
        .active    (arp_active)
    );

    activity_stretch #(.stretch_dw(stretch_dw)) u_rx_stretch (
        .clk_1x_90 (clk_1x_90),
        .arst_n    (arst_n),
        .trig      (rx_event.frame_ok),
        .active    (rx_active)
    );

    activity_stretch #(.stretch_dw(stretch_dw)) u_err_stretch (
        .clk_1x_90 (clk_1x_90),
        .arst_n    (arst_n),
        .trig      (rx_event.frame_err),
        .active    (err_active)
    );

    // Assemble the LED vector
    always_comb begin
        led_nxt = '0;
        led_nxt[led_heartbeat] = blink_cnt[blink_dw-1];
        led_nxt[led_arp] = arp_active;
        led_nxt[led_rx] = rx_active;
        led_nxt[led_err] = err_active;
    end

    // Registered pin drive
    always_ff @(posedge clk_1x_90 or negedge arst_n) begin
        if (!arst_n) begin
            led <= '0;
        end else begin
            led <= led_nxt;
        end
    end

endmodule

//--- gmii_shell_top.sv
`timescale 1ns/1ps

module gmii_shell_top #(
    // Locally managed unicast address
    parameter eth_pkg::mac_addr_t station_mac = 48'h125555000126,
    parameter int stretch_dw = 22,
    parameter int blink_dw = 25
) (
    input  logic                 clk_1x_90,
    input  logic                 arst_n,
    input  eth_pkg::octet_t      gmii_rxd,
    input  logic                 gmii_rx_dv,
    input  logic                 gmii_rx_er,
    output shell_pkg::rx_event_t rx_event,
    output shell_pkg::led_t      led
);
    import eth_pkg::*;

    // Parser to decoder
    octet_t hdr_byte;
    logic   hdr_byte_en;
    logic   hdr_done;
    logic   frame_end;
    logic   frame_bad;

    gmii_rx_parser u_parser (
        .clk_1x_90   (clk_1x_90),
        .arst_n      (arst_n),
        .gmii_rxd    (gmii_rxd),
        .gmii_rx_dv  (gmii_rx_dv),
        .gmii_rx_er  (gmii_rx_er),
        .hdr_byte    (hdr_byte),
        .hdr_byte_en (hdr_byte_en),
        .hdr_done    (hdr_done),
        .frame_end   (frame_end),
        .frame_bad   (frame_bad)
    );

    rx_header_decode #(.station_mac(station_mac)) u_decode (
        .clk_1x_90   (clk_1x_90),
        .arst_n      (arst_n),
        .hdr_byte    (hdr_byte),
        .hdr_byte_en (hdr_byte_en),
        .hdr_done    (hdr_done),
        .frame_end   (frame_end),
        .frame_bad   (frame_bad),
        .rx_event    (rx_event)
    );

    // Board LEDs from the receive events
    status_leds #(
        .stretch_dw (stretch_dw),
        .blink_dw   (blink_dw)
    ) u_leds (
        .clk_1x_90 (clk_1x_90),
        .arst_n    (arst_n),
        .rx_event  (rx_event),
        .led       (led)
    );

endmodule

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk_1x_90,
    output logic arst_n
);

    // 8 ns period
    initial begin
        clk_1x_90 = 1'b0;
        forever #4 clk_1x_90 = ~clk_1x_90;
    end

    // Reset held for 8 cycles, released away from the rising edge
    initial begin
        arst_n = 1'b0;
        repeat (8) @(posedge clk_1x_90);
        @(negedge clk_1x_90);
        arst_n = 1'b1;
    end

endmodule

//--- tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
    input  logic                 clk_1x_90,
    input  logic                 arst_n,
    input  shell_pkg::rx_event_t rx_event,
    input  shell_pkg::led_t      led,
    input  shell_pkg::rx_event_t exp_event,
    input  logic                 frame_sent,
    output int                   frames_checked,
    output int                   pass_cnt,
    output int                   err_cnt
);
    import shell_pkg::*;

    // Events must show up by this many cycles after the frame
    localparam int event_timeout = 10;
    localparam int event_latency = 3;
    localparam int hold_cycles = 16;
    localparam int blink_half = 16;

    // LED bits expected to light for a given outcome
    function automatic led_t leds_for(input rx_event_t ev);
        led_t m;
        m = '0;
        m[led_arp] = ev.arp_ok;
        m[led_rx] = ev.frame_ok;
        m[led_err] = ev.frame_err;
        return m;
    endfunction

    task automatic check_frame(input rx_event_t exp, input int idx);
        int        cnt;
        int        hold;
        int        bad;
        rx_event_t seen;
        led_t      mask;
        cnt = 0;
        bad = 0;
        seen = '0;
        // Watch for the first event pulse
        while ((cnt < event_timeout) && (seen == '0)) begin
            @(negedge clk_1x_90);
            cnt++;
            seen = rx_event;
        end
        if (exp == '0) begin
            if (seen != '0) begin
                $display("mismatch at %0t: frame %0d gave event %b, expected none",
                         $time, idx, seen);
                bad = 1;
            end
        end else if (seen == '0) begin
            $display("frame %0d: timed out, no receive event within %0d cycles",
                     idx, event_timeout);
            bad = 1;
        end else if (seen != exp) begin
            $display("mismatch at %0t: frame %0d gave event %b, expected %b",
                     $time, idx, seen, exp);
            bad = 1;
        end else if (cnt != event_latency) begin
            $display("mismatch at %0t: frame %0d event after %0d cycles, expected %0d",
                     $time, idx, cnt, event_latency);
            bad = 1;
        end
        // Stretched LEDs rise the cycle after the pulse
        mask = leds_for(exp);
        if ((bad == 0) && (mask != '0)) begin
            hold = 0;
            @(negedge clk_1x_90);
            while (((led & mask) == mask) && (hold < 4 * hold_cycles)) begin
                hold++;
                @(negedge clk_1x_90);
            end
            if ((hold != hold_cycles) || ((led & mask) != '0)) begin
                $display("mismatch at %0t: frame %0d LED %b held %0d cycles, expected %0d",
                         $time, idx, mask, hold, hold_cycles);
                bad = 1;
            end
        end
        if (bad == 0) begin
            $display("frame %0d: pass", idx);
            pass_cnt++;
        end else begin
            $display("frame %0d: FAIL", idx);
            err_cnt++;
        end
        frames_checked++;
    endtask

    initial begin
        frames_checked = 0;
        pass_cnt = 0;
        err_cnt = 0;
        forever begin
            // frame_sent changes on the falling edge
            @(posedge clk_1x_90);
            if (frame_sent) begin
                check_frame(exp_event, frames_checked);
            end
        end
    end

    // Heartbeat half period
    initial begin
        logic prev;
        int   since;
        int   started;
        prev = 1'b0;
        since = 0;
        started = 0;
        forever begin
            @(negedge clk_1x_90);
            if (!arst_n) begin
                prev = 1'b0;
                since = 0;
                started = 0;
            end else if (led[led_heartbeat] != prev) begin
                if ((started != 0) && (since != blink_half)) begin
                    $display("mismatch at %0t: heartbeat toggled after %0d cycles, expected %0d",
                             $time, since, blink_half);
                    err_cnt++;
                end
                started = 1;
                since = 1;
                prev = led[led_heartbeat];
            end else begin
                since++;
            end
        end
    end

endmodule

//--- tb_asserts.sv
`timescale 1ns/1ps

module tb_asserts (
    input logic                 clk_1x_90,
    input logic                 arst_n,
    input logic                 hdr_byte_en,
    input logic                 frame_end,
    input shell_pkg::rx_event_t rx_event
);

    // Header strobes seen in the current frame
    logic [4:0] hdr_seen;

    // Failed assertions so far
    int fail_cnt = 0;

    always_ff @(posedge clk_1x_90 or negedge arst_n) begin
        if (!arst_n) begin
            hdr_seen <= '0;
        end else if (frame_end) begin
            hdr_seen <= '0;
        end else if (hdr_byte_en) begin
            hdr_seen <= hdr_seen + 5'd1;
        end
    end

    a_hdr_count: assert property (@(posedge clk_1x_90) disable iff (!arst_n)
        hdr_byte_en |-> (hdr_seen < 5'd14))
        else begin
            $error("more than 14 header strobes in one frame");
            fail_cnt++;
        end

    a_ok_pulse: assert property (@(posedge clk_1x_90) disable iff (!arst_n)
        rx_event.frame_ok |=> !rx_event.frame_ok)
        else begin
            $error("frame_ok longer than one cycle");
            fail_cnt++;
        end

    a_arp_pulse: assert property (@(posedge clk_1x_90) disable iff (!arst_n)
        rx_event.arp_ok |=> !rx_event.arp_ok)
        else begin
            $error("arp_ok longer than one cycle");
            fail_cnt++;
        end

    a_err_pulse: assert property (@(posedge clk_1x_90) disable iff (!arst_n)
        rx_event.frame_err |=> !rx_event.frame_err)
        else begin
            $error("frame_err longer than one cycle");
            fail_cnt++;
        end

    // Error and success are exclusive
    a_err_excl: assert property (@(posedge clk_1x_90) disable iff (!arst_n)
        !(rx_event.frame_err && rx_event.frame_ok))
        else begin
            $error("frame_err together with frame_ok");
            fail_cnt++;
        end

endmodule

//--- tb_top.sv
`timescale 1ns/1ps

module tb_top;
    import eth_pkg::*;
    import shell_pkg::*;

    localparam mac_addr_t station_mac = 48'h125555000126;
    localparam mac_addr_t src_mac = 48'h020000000001;
    localparam int max_frames = 32;
    localparam int cols = 7;

    logic                clk_1x_90;
    logic                arst_n;
    octet_t              gmii_rxd;
    logic                gmii_rx_dv;
    logic                gmii_rx_er;
    rx_event_t           rx_event;
    led_t                led;
    rx_event_t           exp_event;
    logic                frame_sent;
    int                  frames_checked;
    int                  pass_cnt;
    int                  err_cnt;
    int                  tb_errs;
    logic [31:0]         lfsr;
    logic [47:0]         stim_mem [0:max_frames*cols-1];

    tb_clock u_clock (
        .clk_1x_90 (clk_1x_90),
        .arst_n    (arst_n)
    );

    gmii_shell_top #(
        .station_mac (station_mac),
        .stretch_dw  (4),
        .blink_dw    (5)
    ) UUT (
        .clk_1x_90  (clk_1x_90),
        .arst_n     (arst_n),
        .gmii_rxd   (gmii_rxd),
        .gmii_rx_dv (gmii_rx_dv),
        .gmii_rx_er (gmii_rx_er),
        .rx_event   (rx_event),
        .led        (led)
    );

    tb_checker u_checker (
        .clk_1x_90      (clk_1x_90),
        .arst_n         (arst_n),
        .rx_event       (rx_event),
        .led            (led),
        .exp_event      (exp_event),
        .frame_sent     (frame_sent),
        .frames_checked (frames_checked),
        .pass_cnt       (pass_cnt),
        .err_cnt        (err_cnt)
    );

    bind gmii_shell_top tb_asserts u_asserts (
        .clk_1x_90   (clk_1x_90),
        .arst_n      (arst_n),
        .hdr_byte_en (hdr_byte_en),
        .frame_end   (frame_end),
        .rx_event    (rx_event)
    );

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Payload byte from eight LFSR steps
    task automatic random_byte(output octet_t b);
        b = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);
            b = {b[6:0], lfsr[0]};
        end
    endtask

    task automatic drive_byte(input octet_t b, input logic er);
        @(negedge clk_1x_90);
        gmii_rxd = b;
        gmii_rx_dv = 1'b1;
        gmii_rx_er = er;
    endtask

    // k counts bytes after the SFD
    task automatic send_frame(input mac_addr_t dst, input ethertype_t etype,
                              input int plen, input logic [7:0] err_idx, input int hdr_sent);
        eth_header_t hdr;
        octet_t      b;
        int          k;
        hdr.dst_mac = dst;
        hdr.src_mac = src_mac;
        hdr.ethertype = etype;
        for (int i = 0; i < 7; i++) begin
            drive_byte(preamble_octet, 1'b0);
        end
        drive_byte(sfd_octet, 1'b0);
        k = 0;
        for (int i = 0; i < hdr_sent; i++) begin
            drive_byte(hdr[111-8*i -: 8], (err_idx != 8'hff) && (k == int'(err_idx)));
            k++;
        end
        // A cut header carries no payload
        if (hdr_sent >= header_len) begin
            for (int i = 0; i < plen; i++) begin
                random_byte(b);
                drive_byte(b, (err_idx != 8'hff) && (k == int'(err_idx)));
                k++;
            end
        end
        @(negedge clk_1x_90);
        gmii_rxd = '0;
        gmii_rx_dv = 1'b0;
        gmii_rx_er = 1'b0;
        frame_sent = 1'b1;
        @(negedge clk_1x_90);
        frame_sent = 1'b0;
        // Interframe gap
        repeat (10) @(negedge clk_1x_90);
    endtask

    initial begin
        int          n;
        int          wait_cnt;
        logic        err_exp;
        gmii_rxd = '0;
        gmii_rx_dv = 1'b0;
        gmii_rx_er = 1'b0;
        frame_sent = 1'b0;
        exp_event = '0;
        tb_errs = 0;
        lfsr = 32'h431e6193;
        // Unused rows stay zero and mark the end
        for (int i = 0; i < max_frames * cols; i++) begin
            stim_mem[i] = '0;
        end
        $readmemh("stim.txt", stim_mem);

        wait_cnt = 0;
        while (!arst_n && (wait_cnt < 50)) begin
            @(negedge clk_1x_90);
            wait_cnt++;
        end
        if (!arst_n) begin
            $display("reset never released");
            tb_errs++;
        end

        n = 0;
        while ((tb_errs == 0) && (n < max_frames) && (stim_mem[n*cols] != '0)) begin
            err_exp = (stim_mem[n*cols+3][7:0] != 8'hff) ||
                      (int'(stim_mem[n*cols+4]) < header_len);
            exp_event.frame_err = err_exp;
            exp_event.frame_ok = stim_mem[n*cols+5][0] && !err_exp;
            exp_event.arp_ok = stim_mem[n*cols+6][0] && !err_exp;
            send_frame(stim_mem[n*cols], stim_mem[n*cols+1][15:0], int'(stim_mem[n*cols+2]),
                       stim_mem[n*cols+3][7:0], int'(stim_mem[n*cols+4]));
            n++;
            // Checker must finish this frame before the next one
            wait_cnt = 0;
            while ((frames_checked < n) && (wait_cnt < 100)) begin
                @(negedge clk_1x_90);
                wait_cnt++;
            end
            if (frames_checked < n) begin
                $display("checker did not finish frame %0d in time", n - 1);
                tb_errs++;
            end
        end

        $display("frames %0d, passed %0d, errors %0d", n, pass_cnt,
                 err_cnt + tb_errs + UUT.u_asserts.fail_cnt);
        if ((err_cnt == 0) && (tb_errs == 0) && (UUT.u_asserts.fail_cnt == 0) &&
            (n > 0)) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- stim.txt
// dst_mac ethertype payload_len err_idx(ff none, counted after SFD) hdr_bytes_sent
// expected_accept expected_arp
125555000126 0800 10 ff 0e 1 0
ffffffffffff 0806 1c ff 0e 1 1
0a0b0c0d0e0f 0800 10 ff 0e 0 0
125555000126 0800 10 05 0e 0 0
125555000126 0800 10 14 0e 0 0
125555000126 0800 10 ff 06 0 0
125555000126 0806 08 ff 0e 1 1
0a0b0c0d0e0f 0806 12 ff 0e 0 0
ffffffffffff 0800 20 ff 0e 1 0
ffffffffffff 0806 10 00 0e 0 0
125555000126 0800 01 ff 00 0 0
125555000126 0806 2e ff 0e 1 1

//--- tb.f
eth_pkg.sv
shell_pkg.sv
gmii_rx_parser.sv
rx_header_decode.sv
activity_stretch.sv
status_leds.sv
gmii_shell_top.sv
tb_clock.sv
tb_checker.sv
tb_asserts.sv
tb_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
OBJ_DIR   ?= obj_dir
FILELIST  ?= tb.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "Variables: VERILATOR TOP OBJ_DIR FILELIST VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
